//--- common/ooo_pkg.sv
package ooo_pkg;

    // datapath and structure sizes
    localparam int XLEN      = 32;
    localparam int NUM_ALU   = 3;
    localparam int ROB_DEPTH = 8;
    localparam int TAG_W     = 3;
    localparam int RS_DEPTH  = 4;
    localparam int NUM_AREGS = 32;

    // index into the reorder buffer
    typedef logic [TAG_W-1:0] rob_tag_t;

    // supported major opcodes
    typedef enum logic [6:0] {
        op_lui = 7'b0110111,
        op_imm = 7'b0010011,
        op_reg = 7'b0110011
    } opcode_t;

    // integer alu operations
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_t;

endpackage

//--- dispatch/rename_table.sv
`timescale 1ns/100ps

module rename_table
import ooo_pkg::*;
(
    input  logic            clk,
    input  logic            rst,

    input  logic [4:0]      rs1_addr_i,
    input  logic [4:0]      rs2_addr_i,
    output logic            rs1_busy_o,
    output logic            rs2_busy_o,
    output rob_tag_t        rs1_tag_o,
    output rob_tag_t        rs2_tag_o,
    output logic [XLEN-1:0] rs1_value_o,
    output logic [XLEN-1:0] rs2_value_o,

    input  logic            alloc_valid_i,
    input  logic [4:0]      alloc_rd_i,
    input  rob_tag_t        alloc_tag_i,

    input  logic            wb_valid_i,
    input  logic [4:0]      wb_rd_i,
    input  rob_tag_t        wb_tag_i,
    input  logic [XLEN-1:0] wb_data_i
);

    logic [XLEN-1:0]      regs [NUM_AREGS];
    logic [NUM_AREGS-1:0] busy;
    rob_tag_t             tags [NUM_AREGS];

    assign rs1_busy_o  = busy[rs1_addr_i];
    assign rs2_busy_o  = busy[rs2_addr_i];
    assign rs1_tag_o   = tags[rs1_addr_i];
    assign rs2_tag_o   = tags[rs2_addr_i];
    assign rs1_value_o = regs[rs1_addr_i];
    assign rs2_value_o = regs[rs2_addr_i];

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= '0;
            for (int r = 0; r < NUM_AREGS; r++)
                regs[r] <= '0;
        end else begin
            // x0 is never written, so it keeps its reset zero
            if (wb_valid_i && wb_rd_i != 5'd0) begin
                regs[wb_rd_i] <= wb_data_i;
                // only the newest producer may release the register
                if (tags[wb_rd_i] == wb_tag_i)
                    busy[wb_rd_i] <= 1'b0;
            end
            // later assignment, so allocation wins on the same register
            if (alloc_valid_i && alloc_rd_i != 5'd0) begin
                busy[alloc_rd_i] <= 1'b1;
                tags[alloc_rd_i] <= alloc_tag_i;
            end
        end
    end

    a_x0_never_busy: assert property (@(posedge clk) disable iff (rst) !busy[0]);

endmodule

//--- dispatch/reservation_station.sv
`timescale 1ns/100ps

module reservation_station
import ooo_pkg::*;
(
    input  logic                clk,
    input  logic                rst,

    input  logic                instr_valid_i,
    input  logic [XLEN-1:0]     instr_i,
    output logic                instr_ready_o,

    input  logic                rob_full_i,
    input  rob_tag_t            alloc_tag_i,
    output logic                alloc_valid_o,
    output logic [4:0]          alloc_rd_o,

    output logic [4:0]          rs1_addr_o,
    output logic [4:0]          rs2_addr_o,
    input  logic                rs1_busy_i,
    input  logic                rs2_busy_i,
    input  rob_tag_t            rs1_tag_i,
    input  rob_tag_t            rs2_tag_i,
    input  logic [XLEN-1:0]     rs1_value_i,
    input  logic [XLEN-1:0]     rs2_value_i,

    output rob_tag_t            rob_rd1_tag_o,
    output rob_tag_t            rob_rd2_tag_o,
    input  logic                rob_rd1_done_i,
    input  logic                rob_rd2_done_i,
    input  logic [XLEN-1:0]     rob_rd1_data_i,
    input  logic [XLEN-1:0]     rob_rd2_data_i,

    input  logic [NUM_ALU-1:0]  alu_ready_i,
    output logic [NUM_ALU-1:0]  issue_valid_o,
    output alu_op_t             issue_op_o  [NUM_ALU],
    output logic [XLEN-1:0]     issue_a_o   [NUM_ALU],
    output logic [XLEN-1:0]     issue_b_o   [NUM_ALU],
    output rob_tag_t            issue_tag_o [NUM_ALU],

    input  logic                cdb_valid_i,
    input  rob_tag_t            cdb_tag_i,
    input  logic [XLEN-1:0]     cdb_data_i
);

    typedef struct packed {
        logic            valid;
        alu_op_t         op;
        logic [XLEN-1:0] a;
        logic            a_rdy;
        rob_tag_t        a_tag;
        logic [XLEN-1:0] b;
        logic            b_rdy;
        rob_tag_t        b_tag;
        rob_tag_t        dst;
    } rs_slot_t;

    // slot 0 always holds the oldest instruction
    rs_slot_t            slots      [RS_DEPTH];
    rs_slot_t            woken      [RS_DEPTH];
    rs_slot_t            slots_next [RS_DEPTH];
    rs_slot_t            new_slot;
    logic [RS_DEPTH-1:0] issued;
    opcode_t             opcode;
    logic                accept;
    logic                use_rs1;
    logic                use_rs2;
    logic [XLEN-1:0]     imm;

    assign opcode        = opcode_t'(instr_i[6:0]);
    assign instr_ready_o = !slots[RS_DEPTH-1].valid && !rob_full_i;
    assign accept        = instr_valid_i && instr_ready_o;
    assign alloc_valid_o = accept;
    assign alloc_rd_o    = instr_i[11:7];
    assign rs1_addr_o    = instr_i[19:15];
    assign rs2_addr_o    = instr_i[24:20];
    assign rob_rd1_tag_o = rs1_tag_i;
    assign rob_rd2_tag_o = rs2_tag_i;
    assign use_rs1       = (opcode != op_lui);
    assign use_rs2       = (opcode == op_reg);
    assign imm           = (opcode == op_lui) ? {instr_i[31:12], 12'b0}
                                              : {{20{instr_i[31]}}, instr_i[31:20]};

    // decode and operand capture
    always_comb begin
        new_slot       = '0;
        new_slot.valid = 1'b1;
        new_slot.dst   = alloc_tag_i;
        new_slot.a_tag = rs1_tag_i;
        new_slot.b_tag = rs2_tag_i;
        new_slot.a_rdy = 1'b1;
        new_slot.b_rdy = 1'b1;
        case (instr_i[14:12])
            3'b000:  new_slot.op = (use_rs2 && instr_i[30]) ? alu_sub : alu_add;
            3'b001:  new_slot.op = alu_sll;
            3'b010:  new_slot.op = alu_slt;
            3'b011:  new_slot.op = alu_sltu;
            3'b100:  new_slot.op = alu_xor;
            3'b101:  new_slot.op = instr_i[30] ? alu_sra : alu_srl;
            3'b110:  new_slot.op = alu_or;
            default: new_slot.op = alu_and;
        endcase
        // lui is 0 + imm
        if (!use_rs1)
            new_slot.op = alu_add;

        if (!use_rs1)
            new_slot.a = '0;
        else if (!rs1_busy_i)
            new_slot.a = rs1_value_i;
        else if (rob_rd1_done_i)
            new_slot.a = rob_rd1_data_i;
        else if (cdb_valid_i && cdb_tag_i == rs1_tag_i)
            new_slot.a = cdb_data_i;
        else
            new_slot.a_rdy = 1'b0;

        if (!use_rs2)
            new_slot.b = imm;
        else if (!rs2_busy_i)
            new_slot.b = rs2_value_i;
        else if (rob_rd2_done_i)
            new_slot.b = rob_rd2_data_i;
        else if (cdb_valid_i && cdb_tag_i == rs2_tag_i)
            new_slot.b = cdb_data_i;
        else
            new_slot.b_rdy = 1'b0;
    end

    // cdb wake-up
    always_comb begin
        for (int s = 0; s < RS_DEPTH; s++) begin
            woken[s] = slots[s];
            if (cdb_valid_i && !slots[s].a_rdy && slots[s].a_tag == cdb_tag_i) begin
                woken[s].a     = cdb_data_i;
                woken[s].a_rdy = 1'b1;
            end
            if (cdb_valid_i && !slots[s].b_rdy && slots[s].b_tag == cdb_tag_i) begin
                woken[s].b     = cdb_data_i;
                woken[s].b_rdy = 1'b1;
            end
        end
    end

    // oldest ready slot goes to the lowest free alu
    always_comb begin
        logic [NUM_ALU-1:0] free;
        logic               placed;
        free          = alu_ready_i;
        issued        = '0;
        issue_valid_o = '0;
        for (int k = 0; k < NUM_ALU; k++) begin
            issue_op_o[k]  = alu_add;
            issue_a_o[k]   = '0;
            issue_b_o[k]   = '0;
            issue_tag_o[k] = '0;
        end
        for (int s = 0; s < RS_DEPTH; s++) begin
            placed = 1'b0;
            for (int k = 0; k < NUM_ALU; k++) begin
                if (!placed && free[k] && slots[s].valid && slots[s].a_rdy && slots[s].b_rdy) begin
                    issue_valid_o[k] = 1'b1;
                    issue_op_o[k]    = slots[s].op;
                    issue_a_o[k]     = slots[s].a;
                    issue_b_o[k]     = slots[s].b;
                    issue_tag_o[k]   = slots[s].dst;
                    free[k]          = 1'b0;
                    issued[s]        = 1'b1;
                    placed           = 1'b1;
                end
            end
        end
    end

    // compact remaining slots, new entry goes behind them
    always_comb begin
        int n;
        n = 0;
        for (int s = 0; s < RS_DEPTH; s++)
            slots_next[s] = '0;
        for (int s = 0; s < RS_DEPTH; s++) begin
            if (woken[s].valid && !issued[s]) begin
                slots_next[n] = woken[s];
                n = n + 1;
            end
        end
        if (accept)
            slots_next[n] = new_slot;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < RS_DEPTH; s++)
                slots[s].valid <= 1'b0;
        end else begin
            slots <= slots_next;
        end
    end

    a_known_opcode: assert property (@(posedge clk) disable iff (rst)
        accept |-> (instr_i[6:0] inside {op_lui, op_imm, op_reg}));

endmodule

//--- hdl/alu_unit.sv
`timescale 1ns/100ps

module alu_unit
import ooo_pkg::*;
(
    input  logic            clk,
    input  logic            rst,

    input  logic            issue_valid_i,
    input  alu_op_t         issue_op_i,
    input  logic [XLEN-1:0] issue_a_i,
    input  logic [XLEN-1:0] issue_b_i,
    input  rob_tag_t        issue_tag_i,

    output logic            ready_o,
    output logic            res_valid_o,
    output rob_tag_t        res_tag_o,
    output logic [XLEN-1:0] res_data_o,
    input  logic            res_grant_i
);

    logic [XLEN-1:0] result;
    logic [4:0]      shamt;

    assign shamt   = issue_b_i[4:0];
    assign ready_o = !res_valid_o;

    always_comb begin
        case (issue_op_i)
            alu_add:  result = issue_a_i + issue_b_i;
            alu_sub:  result = issue_a_i - issue_b_i;
            alu_sll:  result = issue_a_i << shamt;
            alu_slt:  result = {31'b0, $signed(issue_a_i) < $signed(issue_b_i)};
            alu_sltu: result = {31'b0, issue_a_i < issue_b_i};
            alu_xor:  result = issue_a_i ^ issue_b_i;
            alu_srl:  result = issue_a_i >> shamt;
            alu_sra:  result = $unsigned($signed(issue_a_i) >>> shamt);
            alu_or:   result = issue_a_i | issue_b_i;
            default:  result = issue_a_i & issue_b_i;
        endcase
    end

    // result held until the bus takes it
    always_ff @(posedge clk) begin
        if (rst)
            res_valid_o <= 1'b0;
        else if (issue_valid_i)
            res_valid_o <= 1'b1;
        else if (res_grant_i)
            res_valid_o <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (issue_valid_i) begin
            res_data_o <= result;
            res_tag_o  <= issue_tag_i;
        end
    end

    a_no_issue_while_held: assert property (@(posedge clk) disable iff (rst)
        issue_valid_i |-> !res_valid_o);

endmodule

//--- hdl/cdb_arbiter.sv
`timescale 1ns/100ps

module cdb_arbiter
import ooo_pkg::*;
(
    input  logic [NUM_ALU-1:0] res_valid_i,
    input  rob_tag_t           res_tag_i  [NUM_ALU],
    input  logic [XLEN-1:0]    res_data_i [NUM_ALU],
    output logic [NUM_ALU-1:0] res_grant_o,

    output logic               cdb_valid_o,
    output rob_tag_t           cdb_tag_o,
    output logic [XLEN-1:0]    cdb_data_o
);

    assign cdb_valid_o = |res_valid_i;

    // scan from the top so the lowest valid index is left standing
    always_comb begin
        res_grant_o = '0;
        cdb_tag_o   = '0;
        cdb_data_o  = '0;
        for (int k = NUM_ALU - 1; k >= 0; k--) begin
            if (res_valid_i[k]) begin
                res_grant_o    = '0;
                res_grant_o[k] = 1'b1;
                cdb_tag_o      = res_tag_i[k];
                cdb_data_o     = res_data_i[k];
            end
        end
    end

endmodule

//--- hdl/reorder_buffer.sv
`timescale 1ns/100ps

module reorder_buffer
import ooo_pkg::*;
(
    input  logic            clk,
    input  logic            rst,

    input  logic            alloc_valid_i,
    input  logic [4:0]      alloc_rd_i,
    output rob_tag_t        alloc_tag_o,
    output logic            full_o,

    input  rob_tag_t        rd1_tag_i,
    input  rob_tag_t        rd2_tag_i,
    output logic            rd1_done_o,
    output logic            rd2_done_o,
    output logic [XLEN-1:0] rd1_data_o,
    output logic [XLEN-1:0] rd2_data_o,

    input  logic            cdb_valid_i,
    input  rob_tag_t        cdb_tag_i,
    input  logic [XLEN-1:0] cdb_data_i,

    output logic            commit_valid_o,
    output logic [4:0]      commit_rd_o,
    output logic [XLEN-1:0] commit_data_o,
    output rob_tag_t        commit_tag_o
);

    logic [ROB_DEPTH-1:0] valid;
    logic [ROB_DEPTH-1:0] done;
    logic [4:0]           dest  [ROB_DEPTH];
    logic [XLEN-1:0]      value [ROB_DEPTH];
    rob_tag_t             head;
    rob_tag_t             tail;
    logic [TAG_W:0]       count;

    assign alloc_tag_o = tail;
    assign full_o      = (count == (TAG_W+1)'(ROB_DEPTH));

    // operand lookup for dispatch
    assign rd1_done_o = valid[rd1_tag_i] && done[rd1_tag_i];
    assign rd2_done_o = valid[rd2_tag_i] && done[rd2_tag_i];
    assign rd1_data_o = value[rd1_tag_i];
    assign rd2_data_o = value[rd2_tag_i];

    // head retires as soon as it is done
    assign commit_valid_o = valid[head] && done[head];
    assign commit_rd_o    = dest[head];
    assign commit_data_o  = value[head];
    assign commit_tag_o   = head;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
            done  <= '0;
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (cdb_valid_i)
                done[cdb_tag_i] <= 1'b1;
            if (commit_valid_o) begin
                valid[head] <= 1'b0;
                done[head]  <= 1'b0;
                head        <= head + 1'b1;
            end
            if (alloc_valid_i) begin
                valid[tail] <= 1'b1;
                done[tail]  <= 1'b0;
                tail        <= tail + 1'b1;
            end
            case ({alloc_valid_i, commit_valid_o})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_valid_i)
            dest[tail] <= alloc_rd_i;
        if (cdb_valid_i)
            value[cdb_tag_i] <= cdb_data_i;
    end

    a_cdb_hits_live_entry: assert property (@(posedge clk) disable iff (rst)
        cdb_valid_i |-> valid[cdb_tag_i]);

endmodule

//--- hdl/ooo_core.sv
`timescale 1ns/100ps

module ooo_core
import ooo_pkg::*;
(
    input  logic            clk,
    input  logic            rst,

    input  logic            instr_valid_i,
    output logic            instr_ready_o,
    input  logic [XLEN-1:0] instr_i,

    output logic            commit_valid_o,
    output logic [4:0]      commit_rd_o,
    output logic [XLEN-1:0] commit_data_o
);

    rob_tag_t           alloc_tag;
    logic               alloc_valid;
    logic [4:0]         alloc_rd;
    logic               rob_full;
    rob_tag_t           commit_tag;

    logic [4:0]         rs1_addr;
    logic [4:0]         rs2_addr;
    logic               rs1_busy;
    logic               rs2_busy;
    rob_tag_t           rs1_tag;
    rob_tag_t           rs2_tag;
    logic [XLEN-1:0]    rs1_value;
    logic [XLEN-1:0]    rs2_value;

    rob_tag_t           rob_rd1_tag;
    rob_tag_t           rob_rd2_tag;
    logic               rob_rd1_done;
    logic               rob_rd2_done;
    logic [XLEN-1:0]    rob_rd1_data;
    logic [XLEN-1:0]    rob_rd2_data;

    logic [NUM_ALU-1:0] alu_ready;
    logic [NUM_ALU-1:0] issue_valid;
    alu_op_t            issue_op  [NUM_ALU];
    logic [XLEN-1:0]    issue_a   [NUM_ALU];
    logic [XLEN-1:0]    issue_b   [NUM_ALU];
    rob_tag_t           issue_tag [NUM_ALU];
    logic [NUM_ALU-1:0] res_valid;
    logic [NUM_ALU-1:0] res_grant;
    rob_tag_t           res_tag   [NUM_ALU];
    logic [XLEN-1:0]    res_data  [NUM_ALU];

    logic               cdb_valid;
    rob_tag_t           cdb_tag;
    logic [XLEN-1:0]    cdb_data;

    reservation_station u_rs (
        .clk            (clk),
        .rst            (rst),
        .instr_valid_i  (instr_valid_i),
        .instr_i        (instr_i),
        .instr_ready_o  (instr_ready_o),
        .rob_full_i     (rob_full),
        .alloc_tag_i    (alloc_tag),
        .alloc_valid_o  (alloc_valid),
        .alloc_rd_o     (alloc_rd),
        .rs1_addr_o     (rs1_addr),
        .rs2_addr_o     (rs2_addr),
        .rs1_busy_i     (rs1_busy),
        .rs2_busy_i     (rs2_busy),
        .rs1_tag_i      (rs1_tag),
        .rs2_tag_i      (rs2_tag),
        .rs1_value_i    (rs1_value),
        .rs2_value_i    (rs2_value),
        .rob_rd1_tag_o  (rob_rd1_tag),
        .rob_rd2_tag_o  (rob_rd2_tag),
        .rob_rd1_done_i (rob_rd1_done),
        .rob_rd2_done_i (rob_rd2_done),
        .rob_rd1_data_i (rob_rd1_data),
        .rob_rd2_data_i (rob_rd2_data),
        .alu_ready_i    (alu_ready),
        .issue_valid_o  (issue_valid),
        .issue_op_o     (issue_op),
        .issue_a_o      (issue_a),
        .issue_b_o      (issue_b),
        .issue_tag_o    (issue_tag),
        .cdb_valid_i    (cdb_valid),
        .cdb_tag_i      (cdb_tag),
        .cdb_data_i     (cdb_data)
    );

    // commit writes the architectural registers
    rename_table u_rename (
        .clk            (clk),
        .rst            (rst),
        .rs1_addr_i     (rs1_addr),
        .rs2_addr_i     (rs2_addr),
        .rs1_busy_o     (rs1_busy),
        .rs2_busy_o     (rs2_busy),
        .rs1_tag_o      (rs1_tag),
        .rs2_tag_o      (rs2_tag),
        .rs1_value_o    (rs1_value),
        .rs2_value_o    (rs2_value),
        .alloc_valid_i  (alloc_valid),
        .alloc_rd_i     (alloc_rd),
        .alloc_tag_i    (alloc_tag),
        .wb_valid_i     (commit_valid_o),
        .wb_rd_i        (commit_rd_o),
        .wb_tag_i       (commit_tag),
        .wb_data_i      (commit_data_o)
    );

    for (genvar k = 0; k < NUM_ALU; k++) begin : g_alu
        alu_unit u_alu (
            .clk            (clk),
            .rst            (rst),
            .issue_valid_i  (issue_valid[k]),
            .issue_op_i     (issue_op[k]),
            .issue_a_i      (issue_a[k]),
            .issue_b_i      (issue_b[k]),
            .issue_tag_i    (issue_tag[k]),
            .ready_o        (alu_ready[k]),
            .res_valid_o    (res_valid[k]),
            .res_tag_o      (res_tag[k]),
            .res_data_o     (res_data[k]),
            .res_grant_i    (res_grant[k])
        );
    end

    cdb_arbiter u_cdb (
        .res_valid_i    (res_valid),
        .res_tag_i      (res_tag),
        .res_data_i     (res_data),
        .res_grant_o    (res_grant),
        .cdb_valid_o    (cdb_valid),
        .cdb_tag_o      (cdb_tag),
        .cdb_data_o     (cdb_data)
    );

    reorder_buffer u_rob (
        .clk            (clk),
        .rst            (rst),
        .alloc_valid_i  (alloc_valid),
        .alloc_rd_i     (alloc_rd),
        .alloc_tag_o    (alloc_tag),
        .full_o         (rob_full),
        .rd1_tag_i      (rob_rd1_tag),
        .rd2_tag_i      (rob_rd2_tag),
        .rd1_done_o     (rob_rd1_done),
        .rd2_done_o     (rob_rd2_done),
        .rd1_data_o     (rob_rd1_data),
        .rd2_data_o     (rob_rd2_data),
        .cdb_valid_i    (cdb_valid),
        .cdb_tag_i      (cdb_tag),
        .cdb_data_i     (cdb_data),
        .commit_valid_o (commit_valid_o),
        .commit_rd_o    (commit_rd_o),
        .commit_data_o  (commit_data_o),
        .commit_tag_o   (commit_tag)
    );

endmodule

//--- verification/ooo_core_tb.sv
`timescale 1ns/100ps

module ooo_core_tb
import ooo_pkg::*;
();

    localparam int NUM_INSTR      = 400;
    localparam int TIMEOUT_CYCLES = NUM_INSTR * 20;

    logic            clk;
    logic            rst;
    logic            instr_valid_i;
    logic            instr_ready_o;
    logic [XLEN-1:0] instr_i;
    logic            commit_valid_o;
    logic [4:0]      commit_rd_o;
    logic [XLEN-1:0] commit_data_o;

    integer          seed = 32'h2318f508;
    logic [31:0]     gap;
    logic [XLEN-1:0] model_regs [NUM_AREGS];
    logic [XLEN-1:0] next_value;
    logic [4:0]      exp_rd_q   [$];
    logic [XLEN-1:0] exp_data_q [$];
    logic [4:0]      exp_rd;
    logic [XLEN-1:0] exp_data;
    int              accept_count = 0;
    int              commit_count = 0;
    int              cycle_count = 0;
    int              n;

    ooo_core u_dut (
        .clk            (clk),
        .rst            (rst),
        .instr_valid_i  (instr_valid_i),
        .instr_ready_o  (instr_ready_o),
        .instr_i        (instr_i),
        .commit_valid_o (commit_valid_o),
        .commit_rd_o    (commit_rd_o),
        .commit_data_o  (commit_data_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1, "run aborted");
    endtask

    // registers x0..x7 only, so dependencies are frequent
    function automatic logic [XLEN-1:0] random_instr();
        logic [31:0] r;
        logic [31:0] r2;
        logic [31:0] ins;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        r   = $random(seed);
        r2  = $random(seed);
        rd  = {2'b0, r[2:0]};
        rs1 = {2'b0, r[5:3]};
        rs2 = {2'b0, r[8:6]};
        f3  = r[11:9];
        case (r[13:12])
            2'b00: ins = {r2[31:12], rd, 7'b0110111};
            2'b01: begin
                ins = {r2[31:20], rs1, f3, rd, 7'b0010011};
                // shift immediates need a legal funct7
                if (f3 == 3'b001)
                    ins[31:25] = 7'b0;
                else if (f3 == 3'b101)
                    ins[31:25] = {1'b0, r2[19], 5'b0};
            end
            default: begin
                ins = {7'b0, rs2, rs1, f3, rd, 7'b0110011};
                if (f3 == 3'b000 || f3 == 3'b101)
                    ins[30] = r2[19];
            end
        endcase
        return ins;
    endfunction

    // RV32I semantics on the model register file
    function automatic logic [XLEN-1:0] execute_model(input logic [XLEN-1:0] ins);
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] res;
        logic            is_reg;
        is_reg = (ins[6:0] == 7'b0110011);
        a = model_regs[ins[19:15]];
        if (is_reg)
            b = model_regs[ins[24:20]];
        else
            b = {{20{ins[31]}}, ins[31:20]};
        case (ins[14:12])
            3'b000:  res = (is_reg && ins[30]) ? a - b : a + b;
            3'b001:  res = a << b[4:0];
            3'b010:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  res = (a < b) ? 32'd1 : 32'd0;
            3'b100:  res = a ^ b;
            3'b101:  res = ins[30] ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  res = a | b;
            default: res = a & b;
        endcase
        if (ins[6:0] == 7'b0110111)
            res = {ins[31:12], 12'b0};
        return res;
    endfunction

    initial begin
        rst           = 1'b1;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        for (int r = 0; r < NUM_AREGS; r++)
            model_regs[r] = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        n   = 0;
        while (n < NUM_INSTR) begin
            gap = $random(seed);
            if (gap[1:0] == 2'b00) begin
                instr_valid_i = 1'b0;
                @(negedge clk);
            end else begin
                instr_i       = random_instr();
                instr_valid_i = 1'b1;
                // hold the word while the core back-pressures
                while (!instr_ready_o)
                    @(negedge clk);
                next_value = execute_model(instr_i);
                exp_rd_q.push_back(instr_i[11:7]);
                exp_data_q.push_back(next_value);
                if (instr_i[11:7] != 5'd0)
                    model_regs[instr_i[11:7]] = next_value;
                accept_count <= accept_count + 1;
                n = n + 1;
                @(negedge clk);
            end
        end
        instr_valid_i = 1'b0;
        wait (commit_count == NUM_INSTR);
        // a duplicated instruction would still commit within this window
        repeat (4 * ROB_DEPTH) @(negedge clk);
        $display("Testbench passed");
        $finish;
    end

    // commit outputs settle after the rising edge, so look at the falling one
    always @(negedge clk) begin
        if (!rst) begin
            if (accept_count == 0)
                assert (!commit_valid_o)
                    else abort_run("commit seen before any instruction was accepted");
            assert (accept_count - commit_count < ROB_DEPTH || !instr_ready_o)
                else abort_run("instr_ready_o high while the reorder buffer is full");
            if (commit_valid_o) begin
                assert (exp_rd_q.size() > 0)
                    else abort_run("commit without any pending instruction");
                exp_rd   = exp_rd_q.pop_front();
                exp_data = exp_data_q.pop_front();
                assert (commit_rd_o == exp_rd)
                    else abort_run($sformatf("mismatch commit_rd_o: got %h, expected %h",
                                             commit_rd_o, exp_rd));
                assert (commit_data_o == exp_data)
                    else abort_run($sformatf("mismatch commit_data_o: got %h, expected %h",
                                             commit_data_o, exp_data));
                commit_count <= commit_count + 1;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
            abort_run($sformatf("timeout after %0d cycles, %0d of %0d instructions committed",
                                cycle_count, commit_count, NUM_INSTR));
    end

endmodule

//--- filelist.f
common/ooo_pkg.sv
dispatch/rename_table.sv
dispatch/reservation_station.sv
hdl/alu_unit.sv
hdl/cdb_arbiter.sv
hdl/reorder_buffer.sv
hdl/ooo_core.sv
verification/ooo_core_tb.sv

//--- Makefile
TOOL     := verilator
TOP      := ooo_core_tb
FILELIST := filelist.f
FLAGS    := --binary --timing --assert
OBJ_DIR  := obj_dir

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "Testbench passed"

clean:
	rm -rf $(OBJ_DIR)
